// ==== include/fm_config.svh ====
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// number of FM channels, one slot each per stage
`define FM_NUM_CH 6

// operator result width, also pcm sample and channel sum
`define FM_OP_W 9

// stereo mix width, holds six sign-extended channel sums
`define FM_MIX_W 12

`endif

// ==== rtl/fm_slot_pkg.sv ====
// slot sequencing types shared by the counter, stage FSM and accumulator
package fm_slot_pkg;

	// operator stages in the order they are visited during a frame
	// S3 comes before S2 to follow the operator pipeline order
	typedef enum logic [1:0] {
		ST_S1 = 2'd0, // first slot group, op1 of every channel
		ST_S3 = 2'd1, // op3
		ST_S2 = 2'd2, // op2
		ST_S4 = 2'd3  // op4, channel sums complete here
	} stage_t;

	// channel index inside a stage, 0 to 5
	// three bits leave codes 6 and 7 unused
	typedef logic [2:0] chan_t;

endpackage

// ==== rtl/fm_voice_pkg.sv ====
// per-channel voice settings, written by the host and read per slot
package fm_voice_pkg;

	// operator connection, sets which operators reach the output
	typedef enum logic [2:0] {
		ALG0 = 3'd0, // serial chain, op4 only
		ALG1 = 3'd1,
		ALG2 = 3'd2,
		ALG3 = 3'd3,
		ALG4 = 3'd4, // two pairs, op2 and op4
		ALG5 = 3'd5, // op1 drives three carriers
		ALG6 = 3'd6,
		ALG7 = 3'd7  // all four operators are carriers
	} alg_t;

	// stereo routing, one enable bit per side
	typedef logic [1:0] pan_t;

	localparam int PAN_R_BIT = 0; // right output enable
	localparam int PAN_L_BIT = 1; // left output enable

	// routed to both sides, used as the reset value
	localparam pan_t PAN_BOTH = 2'b11;

endpackage

// ==== rtl/fm_chan_counter.sv ====
`timescale 1ns/1ps
`include "fm_config.svh"

// channel slot counter, steps once per clock through one stage
module fm_chan_counter
	import fm_slot_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	output chan_t chan,      // channel of the current slot
	output logic  last_chan  // high while chan is the last channel
);

	localparam chan_t LAST_CH = chan_t'(`FM_NUM_CH - 1);

	// end of stage, the FSM moves on here
	assign last_chan = (chan == LAST_CH);

	always_ff @(posedge clk) begin
		if (rst) begin
			chan <= '0; // frame starts at channel 0
		end else if (last_chan) begin
			chan <= '0; // wrap into next stage
		end else begin
			chan <= chan + chan_t'(1);
		end
	end

endmodule

// ==== rtl/fm_stage_fsm.sv ====
`timescale 1ns/1ps

// stage sequencer, S1 -> S3 -> S2 -> S4 and back, six slots per stage
module fm_stage_fsm
	import fm_slot_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   last_chan, // last channel of the stage
	output stage_t stage,
	output logic   s1_enters,
	output logic   s2_enters,
	output logic   s3_enters,
	output logic   s4_enters
);

	stage_t state;
	stage_t state_nxt;

	always_comb begin
		state_nxt = state; // hold through the six channel slots
		if (last_chan) begin
			case (state)
				ST_S1:   state_nxt = ST_S3;
				ST_S3:   state_nxt = ST_S2;
				ST_S2:   state_nxt = ST_S4;
				default: state_nxt = ST_S1; // S4 closes the frame
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_S1;
		end else begin
			state <= state_nxt;
		end
	end

	assign stage = state;

	// one-hot stage strobes, each high for all six slots of its stage
	// these mirror the strobe interface the accumulator expects
	assign s1_enters = (state == ST_S1);
	assign s2_enters = (state == ST_S2);
	assign s3_enters = (state == ST_S3);
	assign s4_enters = (state == ST_S4);

endmodule

// ==== rtl/fm_chan_regs.sv ====
`timescale 1ns/1ps
`include "fm_config.svh"

// per-channel algorithm and pan storage
// written by a single strobe, read combinationally by slot channel
module fm_chan_regs
	import fm_slot_pkg::*;
	import fm_voice_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  wr_en,  // one-cycle write strobe
	input  chan_t wr_ch,
	input  alg_t  wr_alg,
	input  pan_t  wr_pan,
	input  chan_t chan,   // channel of the current slot
	output alg_t  alg,
	output pan_t  pan
);

	localparam chan_t NUM_CH = chan_t'(`FM_NUM_CH);

	alg_t alg_mem [`FM_NUM_CH];
	pan_t pan_mem [`FM_NUM_CH];

	logic wr_ok; // channel number in range
	logic rd_ok;

	assign wr_ok = wr_en && (wr_ch < NUM_CH); // codes 6 and 7 dropped
	assign rd_ok = (chan < NUM_CH);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_NUM_CH; i++) begin
				alg_mem[i] <= ALG0;
				pan_mem[i] <= PAN_BOTH; // centre by default
			end
		end else if (wr_ok) begin
			alg_mem[wr_ch] <= wr_alg; // visible from the next slot on
			pan_mem[wr_ch] <= wr_pan;
		end
	end

	// zero latency read for the slot being processed
	// the counter never leaves 0..5, the guard only covers unused codes
	assign alg = rd_ok ? alg_mem[chan] : ALG0;
	assign pan = rd_ok ? pan_mem[chan] : PAN_BOTH;

endmodule

// ==== rtl/fm_delay_line.sv ====
`timescale 1ns/1ps

// fixed-depth shift register
// with depth equal to the channel count each channel finds its own
// value again at its next slot, so it acts as circular storage
module fm_delay_line #(
	parameter int width = 9,
	parameter int depth = 6
) (
	input  logic             clk,
	input  logic [width-1:0] din,
	output logic [width-1:0] drop  // din from depth cycles ago
);

	logic [width-1:0] taps [depth];

	always_ff @(posedge clk) begin
		taps[0] <= din;
		for (int i = 1; i < depth; i++) begin
			taps[i] <= taps[i-1];
		end
	end

	assign drop = taps[depth-1];

endmodule

// ==== rtl/fm_op_acc.sv ====
`timescale 1ns/1ps
`include "fm_config.svh"

// operator accumulator and stereo mixer
// sums carriers per channel in a circulating line, then mixes the
// completed sums of the previous frame during the S1 slots
module fm_op_acc
	import fm_slot_pkg::*;
	import fm_voice_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic signed [`FM_OP_W-1:0]  op_result, // operator of the current slot
	input  logic [`FM_OP_W-1:0]         pcm,
	input  logic                        pcm_en,    // replaces channel 5
	input  chan_t                       chan,
	input  alg_t                        alg,
	input  pan_t                        pan,
	input  logic                        s1_enters,
	input  logic                        s2_enters,
	input  logic                        s3_enters,
	input  logic                        s4_enters,
	output logic signed [`FM_MIX_W-1:0] left,
	output logic signed [`FM_MIX_W-1:0] right,
	output logic                        sample     // new stereo pair
);

	localparam chan_t LAST_CH = chan_t'(`FM_NUM_CH - 1);
	localparam int EXT_W = `FM_MIX_W - `FM_OP_W;

	logic                        sum_en;    // current operator is a carrier
	logic                        pcm_slot;
	logic                        mix_last;  // final S1 slot, mix complete
	logic signed [`FM_OP_W-1:0]  pcm_val;
	logic signed [`FM_OP_W-1:0]  next_op;
	logic signed [`FM_OP_W-1:0]  opsum;     // new partial sum into the line
	logic signed [`FM_OP_W-1:0]  total;     // partial sum from the last stage
	logic signed [`FM_OP_W-1:0]  buf_din;
	logic signed [`FM_OP_W-1:0]  done_sum;  // completed sum of last frame
	logic signed [`FM_MIX_W-1:0] done_ext;
	logic signed [`FM_MIX_W-1:0] mix_l;
	logic signed [`FM_MIX_W-1:0] mix_r;
	logic signed [`FM_MIX_W-1:0] next_l;
	logic signed [`FM_MIX_W-1:0] next_r;
	logic signed [`FM_MIX_W-1:0] pre_left;
	logic signed [`FM_MIX_W-1:0] pre_right;

	// carrier table
	always_comb begin
		case (alg)
			ALG4:       sum_en = s2_enters | s4_enters;
			ALG5, ALG6: sum_en = s2_enters | s3_enters | s4_enters; // op2, op3 and op4
			ALG7:       sum_en = 1'b1;
			default:    sum_en = s4_enters;   // ALG0..ALG3, op4 only
		endcase
	end

	assign pcm_slot = pcm_en && (chan == LAST_CH);
	assign pcm_val  = {~pcm[`FM_OP_W-1], pcm[`FM_OP_W-2:0]}; // offset binary to signed
	assign next_op  = sum_en ? op_result : '0;

	always_comb begin
		if (s1_enters) begin
			// S1 opens a fresh sum for this channel
			opsum = pcm_slot ? pcm_val : next_op;
		end else if (sum_en && !pcm_slot) begin
			opsum = total + op_result; // carry dropped, 9-bit wrap
		end else begin
			opsum = total; // modulator or pcm, sum passes unchanged
		end
	end

	fm_delay_line #(
		.width (`FM_OP_W),
		.depth (`FM_NUM_CH)
	) u_acc (
		.clk  (clk),
		.din  (opsum),
		.drop (total)
	);

	// output buffer takes each sum as it completes at S4
	// and recirculates it until the next frame's S4
	assign buf_din = s4_enters ? opsum : done_sum;

	fm_delay_line #(
		.width (`FM_OP_W),
		.depth (`FM_NUM_CH)
	) u_buf (
		.clk  (clk),
		.din  (buf_din),
		.drop (done_sum) // lines up with the S1 slot of the same channel
	);

	assign done_ext = {{EXT_W{done_sum[`FM_OP_W-1]}}, done_sum};
	assign mix_l    = pan[PAN_L_BIT] ? done_ext : '0;
	assign mix_r    = pan[PAN_R_BIT] ? done_ext : '0;

	// stereo adders restart at channel 0, 12-bit wrap
	assign next_l   = ((chan == '0) ? '0 : pre_left) + mix_l;
	assign next_r   = ((chan == '0) ? '0 : pre_right) + mix_r;
	assign mix_last = s1_enters && (chan == LAST_CH);

	always_ff @(posedge clk) begin
		if (s1_enters) begin
			pre_left  <= next_l;
			pre_right <= next_r;
		end
		if (mix_last) begin
			left  <= next_l; // shows on the first S3 cycle
			right <= next_r;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sample <= 1'b0;
		end else begin
			sample <= mix_last; // same cycle the outputs change
		end
	end

endmodule

// ==== rtl/fm_out_top.sv ====
`timescale 1ns/1ps
`include "fm_config.svh"

// FM output stage, slot sequencer plus channel registers plus mixer
module fm_out_top
	import fm_slot_pkg::*;
	import fm_voice_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic signed [`FM_OP_W-1:0]  op_result,
	input  logic [`FM_OP_W-1:0]         pcm,
	input  logic                        pcm_en,
	input  logic                        wr_en,
	input  chan_t                       wr_ch,
	input  alg_t                        wr_alg,
	input  pan_t                        wr_pan,
	output logic signed [`FM_MIX_W-1:0] left,
	output logic signed [`FM_MIX_W-1:0] right,
	output logic                        sample
);

	chan_t  chan;
	logic   last_chan;
	stage_t stage;     // current stage, watched by the bound checks
	logic   s1_enters;
	logic   s2_enters;
	logic   s3_enters;
	logic   s4_enters;
	alg_t   alg;       // settings of the slot channel
	pan_t   pan;

	fm_chan_counter u_cnt (
		.clk       (clk),
		.rst       (rst),
		.chan      (chan),
		.last_chan (last_chan)
	);

	fm_stage_fsm u_fsm (
		.clk       (clk),
		.rst       (rst),
		.last_chan (last_chan),
		.stage     (stage),
		.s1_enters (s1_enters),
		.s2_enters (s2_enters),
		.s3_enters (s3_enters),
		.s4_enters (s4_enters)
	);

	fm_chan_regs u_regs (
		.clk    (clk),
		.rst    (rst),
		.wr_en  (wr_en),
		.wr_ch  (wr_ch),
		.wr_alg (wr_alg),
		.wr_pan (wr_pan),
		.chan   (chan),
		.alg    (alg),
		.pan    (pan)
	);

	fm_op_acc u_acc (
		.clk       (clk),
		.rst       (rst),
		.op_result (op_result),
		.pcm       (pcm),
		.pcm_en    (pcm_en),
		.chan      (chan),
		.alg       (alg),
		.pan       (pan),
		.s1_enters (s1_enters),
		.s2_enters (s2_enters),
		.s3_enters (s3_enters),
		.s4_enters (s4_enters),
		.left      (left),
		.right     (right),
		.sample    (sample)
	);

endmodule

// ==== verif/fm_out_props.sv ====
`timescale 1ns/1ps

// sequencing and strobe rules, bound into fm_out_top
module fm_out_props
	import fm_slot_pkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   sample,
	input chan_t  chan,
	input stage_t stage,
	input logic   s1_enters,
	input logic   s2_enters,
	input logic   s3_enters,
	input logic   s4_enters
);

	logic       seen; // one pulse already gone by
	logic [4:0] gap;  // cycles since the last pulse

	always_ff @(posedge clk) begin
		if (rst) begin
			seen <= 1'b0;
			gap  <= '0;
		end else if (sample) begin
			seen <= 1'b1;
			gap  <= '0;
		end else begin
			gap <= gap + 5'd1;
		end
	end

	a_sample_width: assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
		else $error("sample high for more than one cycle");

	// one frame between pulses
	a_sample_gap: assert property (@(posedge clk) disable iff (rst)
		(sample && seen) |-> (gap == 5'd23))
		else $error("sample pulses not 24 cycles apart, gap %0d", gap + 1);

	// new pair lands on the first S3 slot
	a_sample_slot: assert property (@(posedge clk) disable iff (rst)
		sample |-> (stage == ST_S3 && chan == '0))
		else $error("sample pulse outside the first S3 slot");

	a_one_stage: assert property (@(posedge clk) disable iff (rst)
		$onehot({s1_enters, s2_enters, s3_enters, s4_enters}))
		else $error("stage strobes not one-hot");

	a_chan_range: assert property (@(posedge clk) disable iff (rst) chan <= chan_t'(5))
		else $error("channel counter out of range: %0d", chan);

endmodule

// ==== verif/fm_out_tb.sv ====
`timescale 1ns/1ps
`include "fm_config.svh"

// testbench for the FM output stage, random operator stream with a
// per-slot log and a reference mix per frame
module fm_out_tb;
	import fm_slot_pkg::*;
	import fm_voice_pkg::*;

	localparam int MAX_FR = 128; // frame log depth, wraps

	logic                       clk = 1'b0;
	logic                       rst = 1'b1;
	logic signed [`FM_OP_W-1:0] op_result = '0;
	logic [`FM_OP_W-1:0]        pcm = '0;
	logic                       pcm_en = 1'b0;
	logic                       wr_en = 1'b0;
	chan_t                      wr_ch = '0;
	alg_t                       wr_alg = ALG0;
	pan_t                       wr_pan = '0;
	logic signed [`FM_MIX_W-1:0] left;
	logic signed [`FM_MIX_W-1:0] right;
	logic                       sample;

	// per-frame log, op index 0..3 stands for op1..op4
	logic [`FM_OP_W-1:0] op_log [MAX_FR][4][`FM_NUM_CH];
	alg_t                alg_log [MAX_FR][4][`FM_NUM_CH]; // alg in force at each slot
	pan_t                pan_log [MAX_FR][`FM_NUM_CH];    // pan at the S1 slot
	logic [`FM_OP_W-1:0] pcm_log [MAX_FR];
	logic                pcm_en_log [MAX_FR];
	int                  tag_log [MAX_FR];                 // test that owns the frame

	alg_t sh_alg [`FM_NUM_CH] = '{default: ALG0}; // register shadow
	pan_t sh_pan [`FM_NUM_CH] = '{default: 2'b11};
	alg_t mix_algs [`FM_NUM_CH] = '{ALG0, ALG2, ALG3, ALG4, ALG5, ALG6};
	logic [7:0] wr_q [$]; // pending writes {ch, alg, pan}
	logic [7:0] wr_word;

	int   rst_cnt = 0;
	int   slot = 0; // slot count since reset release
	int   fr, pos, op, ch;
	int   cur_test = 0;
	logic pcm_test = 1'b0; // pcm on odd frames
	logic rand_wr = 1'b0;  // random register rewrites
	int   n_pulse = 0;
	int   f, fi, fn, tag;
	logic [2*`FM_MIX_W-1:0] exp_lr;
	int   test_checks [6] = '{default: 0};
	int   test_errs [6] = '{default: 0};
	int   total_checks = 0;
	int   err_count = 0;
	logic timed_out = 1'b0;

	fm_out_top DUT (.*);

	bind fm_out_top fm_out_props u_props (
		.clk(clk), .rst(rst), .sample(sample), .chan(chan), .stage(stage),
		.s1_enters(s1_enters), .s2_enters(s2_enters),
		.s3_enters(s3_enters), .s4_enters(s4_enters)
	);

	always #4 clk = ~clk; // 8 ns period

	// carrier table, k is 0..3 for op1..op4
	function automatic logic is_carrier(input alg_t a, input int k);
		case (a)
			ALG7:       return 1'b1;
			ALG5, ALG6: return k != 0;
			ALG4:       return k == 1 || k == 3;
			default:    return k == 3;
		endcase
	endfunction

	// expected {left, right} for frame fi, pan taken from frame fn
	function automatic logic [2*`FM_MIX_W-1:0] ref_mix(input int fi, input int fn);
		logic [`FM_OP_W-1:0]  sum;
		logic [`FM_MIX_W-1:0] ext;
		logic [`FM_MIX_W-1:0] acc_l;
		logic [`FM_MIX_W-1:0] acc_r;
		int c;
		int k;
		acc_l = '0;
		acc_r = '0;
		for (c = 0; c < `FM_NUM_CH; c++) begin
			sum = '0;
			if (pcm_en_log[fi] && c == `FM_NUM_CH - 1) begin
				sum = pcm_log[fi] ^ 9'h100; // sign bit flipped
			end else begin
				for (k = 0; k < 4; k++)
					if (is_carrier(alg_log[fi][k][c], k))
						sum = sum + op_log[fi][k][c]; // carry lost
			end
			ext = {{(`FM_MIX_W - `FM_OP_W){sum[`FM_OP_W-1]}}, sum};
			if (pan_log[fn][c][1]) acc_l = acc_l + ext;
			if (pan_log[fn][c][0]) acc_r = acc_r + ext;
		end
		return {acc_l, acc_r};
	endfunction

	// slot driver, also releases reset after two cycles
	always @(negedge clk) begin
		if (rst) begin
			rst_cnt++;
			if (rst_cnt == 2) rst = 1'b0;
		end
		if (!rst) begin
			fr  = (slot / 24) % MAX_FR;
			pos = slot % 24;
			ch  = pos % `FM_NUM_CH;
			case (pos / `FM_NUM_CH) // stage order S1 S3 S2 S4
				0:       op = 0;
				1:       op = 2;
				2:       op = 1;
				default: op = 3;
			endcase
			if (pos == 0) begin
				pcm_en = pcm_test && ((slot / 24) % 2 == 1);
				pcm    = 9'($urandom);
				pcm_en_log[fr] = pcm_en;
				pcm_log[fr]    = pcm;
				tag_log[fr]    = cur_test;
			end
			op_result = 9'($urandom);
			op_log[fr][op][ch]  = op_result;
			alg_log[fr][op][ch] = sh_alg[ch];
			if (op == 0) pan_log[fr][ch] = sh_pan[ch];
			wr_en = 1'b0;
			if (wr_q.size() > 0) begin
				wr_word = wr_q.pop_front();
				wr_en   = 1'b1;
			end else if (rand_wr && $urandom_range(7, 0) == 0) begin
				wr_word = 8'($urandom); // channel codes 6 and 7 included
				wr_en   = 1'b1;
			end
			if (wr_en) begin
				wr_ch  = wr_word[7:5];
				wr_alg = alg_t'(wr_word[4:2]);
				wr_pan = wr_word[1:0];
				if (wr_ch < 3'd6) begin // takes effect next slot
					sh_alg[wr_ch] = wr_alg;
					sh_pan[wr_ch] = wr_pan;
				end
			end
			slot++;
		end
	end

	// compare at each sample pulse, pulse k carries frame k-2
	always @(negedge clk) begin
		if (!rst && sample) begin
			n_pulse++;
			if (n_pulse > 2) begin
				f      = n_pulse - 2;
				fi     = f % MAX_FR;
				fn     = (f + 1) % MAX_FR; // pan is read while the mix runs
				tag    = tag_log[fi];
				exp_lr = ref_mix(fi, fn);
				if (left !== exp_lr[2*`FM_MIX_W-1:`FM_MIX_W]) begin
					$display("MISMATCH left frame %0d expected %h actual %h",
						f, exp_lr[2*`FM_MIX_W-1:`FM_MIX_W], left);
					test_errs[tag]++;
					err_count++;
				end
				if (right !== exp_lr[`FM_MIX_W-1:0]) begin
					$display("MISMATCH right frame %0d expected %h actual %h",
						f, exp_lr[`FM_MIX_W-1:0], right);
					test_errs[tag]++;
					err_count++;
				end
				test_checks[tag]++;
				total_checks++;
			end
		end
	end

	task automatic start_test(input int id, input logic pcm_mode, input logic rnd_mode);
		@(posedge clk); // away from the negedge driver
		cur_test = id;
		pcm_test = pcm_mode;
		rand_wr  = rnd_mode;
	endtask

	task automatic queue_write(input int c, input alg_t a, input pan_t p);
		wr_q.push_back({3'(c), a, p});
	endtask

	task automatic run_test(input int id, input int nframes, input string name);
		int n;
		int start;
		while (!timed_out && test_checks[id] < nframes) begin
			start = total_checks;
			n = 0;
			while (total_checks == start && n < 100) begin
				@(posedge clk);
				n++;
			end
			if (total_checks == start) begin
				$display("timeout, no sample pulse within 100 cycles in test %0d", id);
				timed_out = 1'b1;
			end
		end
		if (!timed_out)
			$display("test %0d %s: %0d frames checked, %0d errors",
				id, name, test_checks[id], test_errs[id]);
	endtask

	initial begin
		void'($urandom(32'h4c41));
		start_test(1, 1'b0, 1'b0);
		for (int i = 0; i < `FM_NUM_CH; i++) queue_write(i, ALG7, 2'b11);
		run_test(1, 4, "alg7 centre");
		start_test(2, 1'b0, 1'b0);
		for (int i = 0; i < `FM_NUM_CH; i++) queue_write(i, mix_algs[i], 2'b11);
		run_test(2, 4, "carrier select");
		start_test(3, 1'b0, 1'b0);
		for (int i = 0; i < `FM_NUM_CH; i++) queue_write(i, ALG7, pan_t'(i % 4));
		run_test(3, 4, "panning");
		start_test(4, 1'b1, 1'b0);
		for (int i = 0; i < `FM_NUM_CH; i++) queue_write(i, ALG4, 2'b11);
		run_test(4, 6, "pcm substitution");
		start_test(5, 1'b0, 1'b1);
		run_test(5, 10, "register rewrites");
		$display("done: %0d checks, %0d errors", total_checks, err_count);
		if (err_count == 0 && !timed_out && total_checks > 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/fm_slot_pkg.sv
rtl/fm_voice_pkg.sv
rtl/fm_chan_counter.sv
rtl/fm_stage_fsm.sv
rtl/fm_chan_regs.sv
rtl/fm_delay_line.sv
rtl/fm_op_acc.sv
rtl/fm_out_top.sv
verif/fm_out_props.sv
verif/fm_out_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := fm_out_tb
RTL_TOP    := fm_out_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := sim failed
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# a crash or failed assertion counts as failure as well
run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation FAILED"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
